// ==== logic/bin_accumulator.sv ====
`timescale 1ns/100ps
`default_nettype none

module bin_accumulator import sifh_pkg::*; (
    input  logic               clk,
    input  logic               combin_res,
    input  logic               s2_valid,
    input  logic               s2_accept,
    input  logic [NB-1:0]      s2_bin,
    input  logic [PIXEL_W-1:0] s2_pixel,
    input  logic               s2_last,
    output logic               s3_valid,
    output logic               s3_accept,
    output logic [COUNT_W-1:0] s3_count,
    output logic [NB-1:0]      s3_bin,
    output logic [PIXEL_W-1:0] s3_pixel,
    output logic               s3_last
);

    // one histogram per pixel
    logic [COUNT_W-1:0] count_ram [RAM_DEPTH];
    // set on first hit, a clear flag means count zero
    logic [RAM_DEPTH-1:0] bin_flags;

    logic [ADDR_W-1:0]  addr;
    logic [COUNT_W-1:0] next_count;
    logic               do_write;

    assign addr = {s2_pixel, s2_bin};

    // stale RAM content is hidden behind the flag
    assign next_count = bin_flags[addr] ? count_ram[addr] + 1'b1 : COUNT_W'(1);

    // last item's write would be wiped by the flash clear anyway
    assign do_write = s2_valid && s2_accept && !s2_last;

    // read-modify-write in one cycle, next hit sees the new value
    always_ff @(posedge clk) begin
        if (do_write) begin
            count_ram[addr] <= next_count;
        end
    end

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            bin_flags <= '0;
            s3_valid  <= 1'b0;
            s3_accept <= 1'b0;
            s3_last   <= 1'b0;
        end else begin
            s3_valid  <= s2_valid;
            s3_accept <= s2_valid && s2_accept;
            s3_last   <= s2_valid && s2_last;
            if (s2_valid && s2_last) begin
                // flash clear between passes
                bin_flags <= '0;
            end else if (do_write) begin
                bin_flags[addr] <= 1'b1;
            end
        end
    end

    // count after this hit, bin and pixel for the peak stage
    always_ff @(posedge clk) begin
        if (s2_valid) begin
            s3_count <= next_count;
            s3_bin   <= s2_bin;
            s3_pixel <= s2_pixel;
        end
    end

    // a binned hit never shows up as a wrapped count
    a_no_wrap: assert property (
        @(posedge clk) disable iff (!combin_res)
        (s2_valid && s2_accept) |=> (s3_count != '0)
    );

endmodule

`default_nettype wire

// ==== logic/bin_mapper.sv ====
`timescale 1ns/100ps
`default_nettype none

module bin_mapper import sifh_pkg::*; (
    input  logic               clk,
    input  logic               combin_res,
    input  pass_t              pass,
    input  logic               s1_valid,
    input  logic [STAMP_W-1:0] s1_stamp,
    input  logic [PIXEL_W-1:0] s1_pixel,
    input  logic               s1_last,
    input  logic [NB-1:0]      coarse_bin,
    output logic [PIXEL_W-1:0] lookup_pixel,
    output logic               s2_valid,
    output logic               s2_accept,
    output logic [NB-1:0]      s2_bin,
    output logic [PIXEL_W-1:0] s2_pixel,
    output logic               s2_last
);

    logic [NB-1:0] upper_bits;
    logic [NB-1:0] lower_bits;
    logic          in_window;
    logic          accept;

    // coarse peak of this stamp's pixel comes back combinationally
    assign lookup_pixel = s1_pixel;

    assign upper_bits = s1_stamp[STAMP_W-1 -: NB];
    assign lower_bits = s1_stamp[NB-1:0];

    // fine window is the pixel's coarse peak bin
    assign in_window = (upper_bits == coarse_bin);

    // coarse pass bins everything
    assign accept = s1_valid && ((pass == PASS_CH) || in_window);

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            s2_valid  <= 1'b0;
            s2_accept <= 1'b0;
            s2_last   <= 1'b0;
        end else begin
            s2_valid  <= s1_valid;
            s2_accept <= accept;
            // a dropped stamp still closes the pass
            s2_last   <= s1_valid && s1_last;
        end
    end

    // bin and pixel are payload only
    always_ff @(posedge clk) begin
        if (s1_valid) begin
            s2_bin   <= (pass == PASS_CH) ? upper_bits : lower_bits;
            s2_pixel <= s1_pixel;
        end
    end

endmodule

`default_nettype wire

// ==== logic/peak_register.sv ====
`timescale 1ns/100ps
`default_nettype none

module peak_register import sifh_pkg::*; (
    input  logic               clk,
    input  logic               combin_res,
    input  pass_t              pass,
    input  logic               s3_valid,
    input  logic               s3_accept,
    input  logic [COUNT_W-1:0] s3_count,
    input  logic [NB-1:0]      s3_bin,
    input  logic [PIXEL_W-1:0] s3_pixel,
    input  logic               s3_last,
    input  logic [PIXEL_W-1:0] lookup_pixel,
    output logic [NB-1:0]      coarse_bin,
    output logic               pass_done,
    output logic               result_valid,
    output logic [PIXEL_W-1:0] result_pixel,
    output logic [NB-1:0]      result_ch,
    output logic [NB-1:0]      result_fh,
    output logic [COUNT_W-1:0] result_count
);

    peak_state_t state;

    // running max and argmax per pixel
    logic [COUNT_W-1:0] max_cnt [PIXEL_NUM];
    logic [NB-1:0]      arg_bin [PIXEL_NUM];
    // coarse peaks kept across the fine pass
    logic [NB-1:0]      coarse_peak [PIXEL_NUM];

    logic [PIXEL_W-1:0] rd_pixel;
    logic               track_hit;
    logic               rd_last;

    // window lookup for the mapper
    assign coarse_bin = coarse_peak[lookup_pixel];

    // strictly greater, so a tie keeps the earlier bin
    assign track_hit = s3_valid && s3_accept && (s3_count > max_cnt[s3_pixel]);

    assign rd_last = (rd_pixel == PIXEL_W'(PIXEL_NUM - 1));

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            state        <= PK_TRACK;
            rd_pixel     <= '0;
            pass_done    <= 1'b0;
            result_valid <= 1'b0;
            for (int p = 0; p < PIXEL_NUM; p++) begin
                max_cnt[p]     <= '0;
                arg_bin[p]     <= '0;
                coarse_peak[p] <= '0;
            end
        end else begin
            pass_done    <= 1'b0;
            result_valid <= 1'b0;
            case (state)
                PK_TRACK: begin
                    if (track_hit) begin
                        max_cnt[s3_pixel] <= s3_count;
                        arg_bin[s3_pixel] <= s3_bin;
                    end
                    if (s3_valid && s3_last) begin
                        if (pass == PASS_CH) begin
                            // commit coarse peaks including the last item
                            for (int p = 0; p < PIXEL_NUM; p++) begin
                                coarse_peak[p] <= (track_hit && s3_pixel == PIXEL_W'(p)) ?
                                                  s3_bin : arg_bin[p];
                                max_cnt[p]     <= '0;
                                arg_bin[p]     <= '0;
                            end
                            pass_done <= 1'b1;
                        end else begin
                            state <= PK_READOUT;
                        end
                    end
                end
                PK_READOUT: begin
                    // one pixel per cycle in pixel order
                    result_valid <= 1'b1;
                    rd_pixel     <= rd_pixel + 1'b1;
                    if (rd_last) begin
                        for (int p = 0; p < PIXEL_NUM; p++) begin
                            max_cnt[p] <= '0;
                            arg_bin[p] <= '0;
                        end
                        rd_pixel  <= '0;
                        pass_done <= 1'b1;
                        state     <= PK_TRACK;
                    end
                end
                default: state <= PK_TRACK;
            endcase
        end
    end

    // result fields are valid only with result_valid
    always_ff @(posedge clk) begin
        if (state == PK_READOUT) begin
            result_pixel <= rd_pixel;
            result_ch    <= coarse_peak[rd_pixel];
            result_fh    <= arg_bin[rd_pixel];
            result_count <= max_cnt[rd_pixel];
        end
    end

    // strobes only while the fine pass is still current
    a_result_in_fine: assert property (
        @(posedge clk) disable iff (!combin_res)
        result_valid |-> (pass == PASS_FH)
    );

endmodule

`default_nettype wire

// ==== logic/sifh_pkg.sv ====
`default_nettype none

package sifh_pkg;

    // timestamp and bin geometry
    localparam int STAMP_W = 8;
    // same width for coarse and fine bins
    localparam int NB = 4;
    localparam int NUM_BINS = 1 << NB;

    // pixel sweep shape
    localparam int PIXEL_NUM = 4;
    localparam int PIXEL_W = 2;
    // stamps per pixel per sweep
    localparam int DATA_NUM = 4;
    // sweeps per pass
    localparam int ACQ_NUM = 3;
    localparam int DATA_CNT_W = $clog2(DATA_NUM);
    localparam int ACQ_CNT_W = $clog2(ACQ_NUM);

    // count RAM, one histogram per pixel
    localparam int COUNT_W = 8;
    localparam int RAM_DEPTH = PIXEL_NUM * NUM_BINS;
    // pixel index on top, bin below
    localparam int ADDR_W = PIXEL_W + NB;

    // pass being collected
    typedef enum logic {PASS_CH, PASS_FH} pass_t;

    // sequencer states
    typedef enum logic {SEQ_COLLECT, SEQ_HOLD} seq_state_t;

    // peak register states
    typedef enum logic {PK_TRACK, PK_READOUT} peak_state_t;

endpackage

`default_nettype wire

// ==== logic/sifh_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module sifh_top import sifh_pkg::*; (
    input  logic               clk,
    input  logic               combin_res,
    input  logic [STAMP_W-1:0] stamp,
    input  logic               stamp_valid,
    output logic               busy,
    output pass_t              pass,
    output logic               result_valid,
    output logic [PIXEL_W-1:0] result_pixel,
    output logic [NB-1:0]      result_ch,
    output logic [NB-1:0]      result_fh,
    output logic [COUNT_W-1:0] result_count
);

    // tagged stamps
    logic               s1_valid;
    logic [STAMP_W-1:0] s1_stamp;
    logic [PIXEL_W-1:0] s1_pixel;
    logic               s1_last;

    // mapped bins
    logic               s2_valid;
    logic               s2_accept;
    logic [NB-1:0]      s2_bin;
    logic [PIXEL_W-1:0] s2_pixel;
    logic               s2_last;

    // counted bins
    logic               s3_valid;
    logic               s3_accept;
    logic [COUNT_W-1:0] s3_count;
    logic [NB-1:0]      s3_bin;
    logic [PIXEL_W-1:0] s3_pixel;
    logic               s3_last;

    // coarse window lookup and pass end
    logic [PIXEL_W-1:0] lookup_pixel;
    logic [NB-1:0]      coarse_bin;
    logic               pass_done;

    stamp_sequencer stamp_sequencer_inst (
        .clk         (clk),
        .combin_res  (combin_res),
        .stamp       (stamp),
        .stamp_valid (stamp_valid),
        .pass_done   (pass_done),
        .busy        (busy),
        .pass        (pass),
        .s1_valid    (s1_valid),
        .s1_stamp    (s1_stamp),
        .s1_pixel    (s1_pixel),
        .s1_last     (s1_last)
    );

    bin_mapper bin_mapper_inst (
        .clk          (clk),
        .combin_res   (combin_res),
        .pass         (pass),
        .s1_valid     (s1_valid),
        .s1_stamp     (s1_stamp),
        .s1_pixel     (s1_pixel),
        .s1_last      (s1_last),
        .coarse_bin   (coarse_bin),
        .lookup_pixel (lookup_pixel),
        .s2_valid     (s2_valid),
        .s2_accept    (s2_accept),
        .s2_bin       (s2_bin),
        .s2_pixel     (s2_pixel),
        .s2_last      (s2_last)
    );

    bin_accumulator bin_accumulator_inst (
        .clk        (clk),
        .combin_res (combin_res),
        .s2_valid   (s2_valid),
        .s2_accept  (s2_accept),
        .s2_bin     (s2_bin),
        .s2_pixel   (s2_pixel),
        .s2_last    (s2_last),
        .s3_valid   (s3_valid),
        .s3_accept  (s3_accept),
        .s3_count   (s3_count),
        .s3_bin     (s3_bin),
        .s3_pixel   (s3_pixel),
        .s3_last    (s3_last)
    );

    peak_register peak_register_inst (
        .clk          (clk),
        .combin_res   (combin_res),
        .pass         (pass),
        .s3_valid     (s3_valid),
        .s3_accept    (s3_accept),
        .s3_count     (s3_count),
        .s3_bin       (s3_bin),
        .s3_pixel     (s3_pixel),
        .s3_last      (s3_last),
        .lookup_pixel (lookup_pixel),
        .coarse_bin   (coarse_bin),
        .pass_done    (pass_done),
        .result_valid (result_valid),
        .result_pixel (result_pixel),
        .result_ch    (result_ch),
        .result_fh    (result_fh),
        .result_count (result_count)
    );

endmodule

`default_nettype wire

// ==== logic/stamp_sequencer.sv ====
`timescale 1ns/100ps
`default_nettype none

module stamp_sequencer import sifh_pkg::*; (
    input  logic               clk,
    input  logic               combin_res,
    input  logic [STAMP_W-1:0] stamp,
    input  logic               stamp_valid,
    input  logic               pass_done,
    output logic               busy,
    output pass_t              pass,
    output logic               s1_valid,
    output logic [STAMP_W-1:0] s1_stamp,
    output logic [PIXEL_W-1:0] s1_pixel,
    output logic               s1_last
);

    seq_state_t state;

    // position of the next stamp within the pass
    logic [DATA_CNT_W-1:0] input_cnt;
    logic [PIXEL_W-1:0]    pixel_cnt;
    logic [ACQ_CNT_W-1:0]  acq_cnt;

    logic take;
    logic input_wrap;
    logic pixel_wrap;
    logic acq_wrap;
    logic pass_last;

    // stamps only count while collecting
    assign take = stamp_valid && (state == SEQ_COLLECT);

    assign input_wrap = (input_cnt == DATA_CNT_W'(DATA_NUM - 1));
    assign pixel_wrap = (pixel_cnt == PIXEL_W'(PIXEL_NUM - 1));
    assign acq_wrap   = (acq_cnt == ACQ_CNT_W'(ACQ_NUM - 1));

    // final stamp of the whole pass wraps all three counters
    assign pass_last = take && input_wrap && pixel_wrap && acq_wrap;

    // busy for the whole drain and readout
    assign busy = (state == SEQ_HOLD);

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            state     <= SEQ_COLLECT;
            pass      <= PASS_CH;
            input_cnt <= '0;
            pixel_cnt <= '0;
            acq_cnt   <= '0;
            s1_valid  <= 1'b0;
            s1_last   <= 1'b0;
            s1_pixel  <= '0;
        end else begin
            s1_valid <= take;
            s1_last  <= pass_last;
            if (take) begin
                // tag with the pixel before the counters move
                s1_pixel  <= pixel_cnt;
                input_cnt <= input_wrap ? '0 : input_cnt + 1'b1;
                if (input_wrap) begin
                    pixel_cnt <= pixel_wrap ? '0 : pixel_cnt + 1'b1;
                    if (pixel_wrap) begin
                        acq_cnt <= acq_wrap ? '0 : acq_cnt + 1'b1;
                    end
                end
            end
            case (state)
                SEQ_COLLECT: begin
                    if (pass_last) begin
                        state <= SEQ_HOLD;
                    end
                end
                SEQ_HOLD: begin
                    // pass end seen downstream, flip to the other pass
                    if (pass_done) begin
                        state <= SEQ_COLLECT;
                        pass  <= (pass == PASS_CH) ? PASS_FH : PASS_CH;
                    end
                end
                default: state <= SEQ_COLLECT;
            endcase
        end
    end

    // stamp payload rides along without reset
    always_ff @(posedge clk) begin
        if (take) begin
            s1_stamp <= stamp;
        end
    end

    // peak register may only close a pass that this block has ended
    a_done_in_hold: assert property (
        @(posedge clk) disable iff (!combin_res)
        pass_done |-> (state == SEQ_HOLD)
    );

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# build the sifh testbench with Verilator, run it, judge the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module sifh_tb -Mdir obj_dir -f sifh.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vsifh_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "test failed" "$LOG"; then
    exit 1
fi
if ! grep -q "test passed" "$LOG"; then
    echo "simulation log has no final verdict"
    exit 1
fi
exit 0

// ==== sifh.f ====
logic/sifh_pkg.sv
logic/stamp_sequencer.sv
logic/bin_mapper.sv
logic/bin_accumulator.sv
logic/peak_register.sv
logic/sifh_top.sv
verification/sifh_checker.sv
verification/sifh_tb.sv

// ==== verification/sifh_checker.sv ====
`timescale 1ns/100ps
`default_nettype none

module sifh_checker import sifh_pkg::*; (
    input  logic               clk,
    input  logic               combin_res,
    input  logic               busy,
    input  pass_t              pass,
    input  logic               result_valid,
    input  logic [PIXEL_W-1:0] result_pixel,
    input  logic [NB-1:0]      result_ch,
    input  logic [NB-1:0]      result_fh,
    input  logic [COUNT_W-1:0] result_count,
    output int                 error_count
);

    // expected results as {ch, fh, count}, in arrival order
    logic [2*NB+COUNT_W-1:0] expected_q [$];
    // results compared so far, also the read index into the queue
    int checked;

    logic [NB-1:0]      exp_ch;
    logic [NB-1:0]      exp_fh;
    logic [COUNT_W-1:0] exp_count;

    // filled by the testbench once a frame's reference is known
    task automatic push_expected(input logic [2*NB+COUNT_W-1:0] res);
        expected_q.push_back(res);
    endtask

    function automatic int pending();
        return expected_q.size() - checked;
    endfunction

    task automatic compare_field(input string field, input int got, input int want);
        if (got != want) begin
            $display("[ERROR] %0d ns: result %0d %s is %0d, expected %0d",
                     $time, checked, field, got, want);
            error_count++;
        end
    endtask

    task automatic print_counts(input int tb_errors, input int timeouts);
        $display("error counts: mismatches %0d, missing results %0d, tb checks %0d, timeouts %0d",
                 error_count, pending(), tb_errors, timeouts);
    endtask

    // mid-cycle sampling, all DUT outputs settled
    always @(negedge clk) begin
        if (combin_res && result_valid) begin
            // readout belongs to the fine pass, inside the busy window
            if (!busy || pass != PASS_FH) begin
                $display("[ERROR] %0d ns: result strobe outside fine readout, busy %0d pass %0d",
                         $time, busy, int'(pass));
                error_count++;
            end
            if (pending() == 0) begin
                // nothing queued means the frame was not complete yet
                $display("[ERROR] %0d ns: result for pixel %0d with no expected result pending",
                         $time, result_pixel);
                error_count++;
            end else begin
                {exp_ch, exp_fh, exp_count} = expected_q[checked];
                // pixel order 0 upward within each readout
                compare_field("result_pixel", int'(result_pixel), checked % PIXEL_NUM);
                compare_field("result_ch", int'(result_ch), int'(exp_ch));
                compare_field("result_fh", int'(result_fh), int'(exp_fh));
                compare_field("result_count", int'(result_count), int'(exp_count));
                checked++;
            end
        end
    end

endmodule

`default_nettype wire

// ==== verification/sifh_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module sifh_tb import sifh_pkg::*; ();

    logic clk = 1'b0;
    logic combin_res;
    logic [STAMP_W-1:0] stamp;
    logic stamp_valid;
    logic busy;
    pass_t pass;
    logic result_valid;
    logic [PIXEL_W-1:0] result_pixel;
    logic [NB-1:0] result_ch;
    logic [NB-1:0] result_fh;
    logic [COUNT_W-1:0] result_count;
    int checker_errors;

    // stamps of one frame in sweep order
    logic [STAMP_W-1:0] ch_stamps [PIXEL_NUM*DATA_NUM*ACQ_NUM];
    logic [STAMP_W-1:0] fh_stamps [PIXEL_NUM*DATA_NUM*ACQ_NUM];

    logic [15:0] lfsr_state;
    int check_errors;
    int timeouts;

    // 20 ns period
    always #10 clk = ~clk;

    sifh_top sifh_top_inst (
        .clk          (clk),
        .combin_res   (combin_res),
        .stamp        (stamp),
        .stamp_valid  (stamp_valid),
        .busy         (busy),
        .pass         (pass),
        .result_valid (result_valid),
        .result_pixel (result_pixel),
        .result_ch    (result_ch),
        .result_fh    (result_fh),
        .result_count (result_count)
    );

    sifh_checker sifh_checker_inst (
        .clk          (clk),
        .combin_res   (combin_res),
        .busy         (busy),
        .pass         (pass),
        .result_valid (result_valid),
        .result_pixel (result_pixel),
        .result_ch    (result_ch),
        .result_fh    (result_fh),
        .result_count (result_count),
        .error_count  (checker_errors)
    );

    // galois form with taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 16'hB400;
        end
        return s >> 1;
    endfunction

    // one lfsr step per bit
    function automatic logic [7:0] take_bits(input int n);
        logic [7:0] v;
        v = 8'd0;
        for (int i = 0; i < n; i++) begin
            v = {v[6:0], lfsr_state[0]};
            lfsr_state = lfsr_step(lfsr_state);
        end
        return v;
    endfunction

    function automatic int pixel_of(input int k);
        return (k / DATA_NUM) % PIXEL_NUM;
    endfunction

    // replays a frame as coarse pass then fine pass into one packed result per pixel
    function automatic logic [PIXEL_NUM*(2*NB+COUNT_W)-1:0] reference_results();
        int hist [PIXEL_NUM][NUM_BINS];
        int best [PIXEL_NUM];
        logic [NB-1:0] peak [PIXEL_NUM];
        logic [NB-1:0] coarse [PIXEL_NUM];
        logic [PIXEL_NUM*(2*NB+COUNT_W)-1:0] packed_res;
        logic [STAMP_W-1:0] s;
        logic [NB-1:0] upper;
        logic [NB-1:0] bin;
        int p;
        for (int ps = 0; ps < 2; ps++) begin
            // empty histograms at the start of each pass
            for (int i = 0; i < PIXEL_NUM; i++) begin
                best[i] = 0;
                peak[i] = '0;
                for (int b = 0; b < NUM_BINS; b++) begin
                    hist[i][b] = 0;
                end
            end
            for (int k = 0; k < PIXEL_NUM*DATA_NUM*ACQ_NUM; k++) begin
                s = (ps == 0) ? ch_stamps[k] : fh_stamps[k];
                p = pixel_of(k);
                upper = s[STAMP_W-1 -: NB];
                // fine pass keeps only stamps in the pixel's coarse peak
                if (ps == 0 || upper == coarse[p]) begin
                    bin = (ps == 0) ? upper : s[NB-1:0];
                    hist[p][bin]++;
                    // strictly greater so the earlier leader keeps a tie
                    if (hist[p][bin] > best[p]) begin
                        best[p] = hist[p][bin];
                        peak[p] = bin;
                    end
                end
            end
            if (ps == 0) begin
                coarse = peak;
            end
        end
        for (int i = 0; i < PIXEL_NUM; i++) begin
            packed_res[i*(2*NB+COUNT_W) +: 2*NB+COUNT_W] =
                {coarse[i], peak[i], COUNT_W'(best[i])};
        end
        return packed_res;
    endfunction

    task automatic check_value(input string what, input int got, input int want);
        if (got != want) begin
            $display("[ERROR] %0d ns: %s is %0d, expected %0d", $time, what, got, want);
            check_errors++;
        end
    endtask

    // each pixel leans toward one coarse bin and one fine offset
    task automatic build_random_frame();
        logic [NB-1:0] coarse_pick [PIXEL_NUM];
        logic [NB-1:0] fine_pick [PIXEL_NUM];
        logic [NB-1:0] upper;
        logic [NB-1:0] lower;
        int p;
        for (int i = 0; i < PIXEL_NUM; i++) begin
            coarse_pick[i] = NB'(take_bits(NB));
            fine_pick[i] = NB'(take_bits(NB));
        end
        for (int k = 0; k < PIXEL_NUM*DATA_NUM*ACQ_NUM; k++) begin
            p = pixel_of(k);
            // three in four on the favored coarse bin
            upper = coarse_pick[p];
            if (take_bits(2) == 8'd0) begin
                upper = NB'(take_bits(NB));
            end
            lower = NB'(take_bits(NB));
            ch_stamps[k] = {upper, lower};
            upper = coarse_pick[p];
            if (take_bits(2) == 8'd0) begin
                upper = NB'(take_bits(NB));
            end
            // half of the fine stamps on the favored offset
            lower = fine_pick[p];
            if (take_bits(1) == 8'd0) begin
                lower = NB'(take_bits(NB));
            end
            fh_stamps[k] = {upper, lower};
        end
    endtask

    // pixel 2 fine stamps all miss its coarse peak
    task automatic build_window_frame();
        build_random_frame();
        for (int k = 0; k < PIXEL_NUM*DATA_NUM*ACQ_NUM; k++) begin
            if (pixel_of(k) == 2) begin
                ch_stamps[k][STAMP_W-1 -: NB] = NB'(5);
                fh_stamps[k][STAMP_W-1 -: NB] = NB'(10);
            end
        end
    endtask

    // two bins per pixel end level and the one hit first should win
    task automatic build_tie_frame();
        logic [NB-1:0] first_bin;
        logic [NB-1:0] second_bin;
        logic [NB-1:0] first_fine;
        logic [NB-1:0] second_fine;
        logic [NB-1:0] lower;
        int p;
        for (int k = 0; k < PIXEL_NUM*DATA_NUM*ACQ_NUM; k++) begin
            p = pixel_of(k);
            // even pixels lead with the higher bin
            first_bin = NB'((p % 2 == 0) ? 12 - p : 2 + p);
            second_bin = NB'((p % 2 == 0) ? 2 + p : 12 - p);
            first_fine = NB'((p % 2 == 0) ? 1 + 3 * p : 15 - p);
            second_fine = NB'((p % 2 == 0) ? 15 - p : 1 + 3 * p);
            lower = NB'(take_bits(NB));
            if ((k % DATA_NUM) % 2 == 0) begin
                ch_stamps[k] = {first_bin, lower};
                fh_stamps[k] = {first_bin, first_fine};
            end else begin
                ch_stamps[k] = {second_bin, lower};
                fh_stamps[k] = {first_bin, second_fine};
            end
        end
    endtask

    // back to back strobes at one per cycle
    task automatic send_pass(input logic fine);
        for (int k = 0; k < PIXEL_NUM*DATA_NUM*ACQ_NUM; k++) begin
            stamp = fine ? fh_stamps[k] : ch_stamps[k];
            stamp_valid = 1'b1;
            @(posedge clk);
            #1;
        end
        stamp_valid = 1'b0;
    endtask

    // busy must rise after the last stamp and junk strobes meanwhile are ignored
    task automatic wait_pass_end(output logic ok);
        int cycles;
        ok = 1'b1;
        cycles = 0;
        check_value("busy after last stamp", int'(busy), 1);
        while (busy && ok) begin
            stamp = STAMP_W'(take_bits(STAMP_W));
            stamp_valid = 1'b1;
            @(posedge clk);
            #1;
            cycles++;
            if (cycles > 64) begin
                $display("timeout: busy stayed high for %0d cycles at the end of a pass", cycles);
                timeouts++;
                ok = 1'b0;
            end
        end
        stamp_valid = 1'b0;
    endtask

    task automatic wait_drained(output logic ok);
        int cycles;
        ok = 1'b1;
        cycles = 0;
        while (sifh_checker_inst.pending() != 0 && ok) begin
            @(posedge clk);
            #1;
            cycles++;
            if (cycles > 16) begin
                $display("timeout: %0d expected results never appeared on the result stream",
                         sifh_checker_inst.pending());
                timeouts++;
                ok = 1'b0;
            end
        end
    endtask

    task automatic run_frame(output logic ok);
        logic [PIXEL_NUM*(2*NB+COUNT_W)-1:0] res;
        send_pass(1'b0);
        wait_pass_end(ok);
        if (ok) begin
            check_value("pass after coarse pass", int'(pass), int'(PASS_FH));
            send_pass(1'b1);
            // queued before the readout can begin
            res = reference_results();
            for (int i = 0; i < PIXEL_NUM; i++) begin
                sifh_checker_inst.push_expected(res[i*(2*NB+COUNT_W) +: 2*NB+COUNT_W]);
            end
            wait_pass_end(ok);
        end
        if (ok) begin
            check_value("pass after fine pass", int'(pass), int'(PASS_CH));
            wait_drained(ok);
        end
    endtask

    task automatic finish_run();
        int total;
        sifh_checker_inst.print_counts(check_errors, timeouts);
        total = checker_errors + sifh_checker_inst.pending() + check_errors + timeouts;
        if (total == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    endtask

    initial begin
        logic ok;
        combin_res = 1'b0;
        stamp = '0;
        stamp_valid = 1'b0;
        lfsr_state = 16'd56144;
        check_errors = 0;
        timeouts = 0;
        repeat (4) @(posedge clk);
        #1;
        combin_res = 1'b1;
        check_value("busy after reset", int'(busy), 0);
        check_value("result_valid after reset", int'(result_valid), 0);
        check_value("pass after reset", int'(pass), int'(PASS_CH));
        ok = 1'b1;
        // three random frames then window and tie frames
        for (int f = 0; f < 5 && ok; f++) begin
            if (f < 3) begin
                build_random_frame();
            end else if (f == 3) begin
                build_window_frame();
            end else begin
                build_tie_frame();
            end
            run_frame(ok);
        end
        finish_run();
    end

endmodule

`default_nettype wire
